// File: Makefile
# Verilator simulation of the issue stage

VERILATOR ?= verilator
TOP       ?= isu_tb
LOG       ?= sim.log
FLAGS     ?= --binary --assert

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/isu_checker.sv
`timescale 1ns/1ns

module isu_checker
    import isu_cfg_pkg::*, isu_types_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       in_valid,
    input logic       in_ready,
    input logic       out_valid,
    input logic       out_ready,
    input issue_pkt_t out_pkt
);

    int unsigned fail_cnt = 0;
    int          in_flight_q;   // Accepted and not yet taken by the FU
    int          waiting;       // Entries still in the queue

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight_q <= 0;
        end else begin
            in_flight_q <= in_flight_q + int'(in_valid && in_ready)
                                       - int'(out_valid && out_ready);
        end
    end

    // One popped entry sits in the output register while out_valid is high
    assign waiting = in_flight_q - int'(out_valid);

    // FU stall holds valid and the whole packet
    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_pkt)))
        else begin
            $error("out_pkt or out_valid changed while the FU stalled");
            fail_cnt++;
        end

    // Nothing to issue right after reset
    reset_idle: assert property (@(posedge clk) $rose(arst_n) |-> !out_valid)
        else begin
            $error("out_valid high in the first cycle after reset");
            fail_cnt++;
        end

    //----------------------------------------------------------------------
    // Rename stalls only with eight entries waiting
    //----------------------------------------------------------------------
    full_stall: assert property (@(posedge clk) disable iff (!arst_n)
        !in_ready |-> (waiting == ISQ_DEPTH))
        else begin
            $error("in_ready low with fewer than eight queued entries");
            fail_cnt++;
        end

endmodule

bind isu_top isu_checker isu_checker_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pkt   (out_pkt)
);

// File: dv/isu_tb.sv
`timescale 1ns/1ns

module isu_tb
    import isu_cfg_pkg::*, isu_types_pkg::*;
();

    localparam int NUM_IDS    = 1 << ID_W;
    localparam int NUM_RANDOM = 200;
    // Directed part about 150 cycles and random part well under 1500
    localparam int MAX_CYCLES = 3000;

    logic       clk;
    logic       arst_n;
    logic       in_valid;
    logic       in_ready;
    disp_req_t  in_req;
    wb_t        wb;
    logic       out_valid;
    logic       out_ready;
    issue_pkt_t out_pkt;

    // Reference model
    logic [NUM_PREGS-1:0] busy_m;
    logic [XLEN-1:0]      regs_m [NUM_PREGS];
    logic [ID_W-1:0]      next_id;
    disp_req_t            pend_req [NUM_IDS];
    logic [NUM_IDS-1:0]   pend_v;           // Accepted and not yet at the FU
    int                   n_pend;
    logic [ID_W-1:0]      got_ids [$];      // Arrival order at the FU
    issue_pkt_t           last_pkt;

    // Sampled in the last tick
    logic                 acc_seen;
    logic                 ov_seen;
    issue_pkt_t           pkt_seen;

    string                cur_test;
    int                   seed = 32'hd4fa;
    int                   cycles;

    isu_top isu_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .wb        (wb),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            fail_now();
        end
    end

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------
    task automatic fail_now();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string what, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s: %s expected %0h actual %0h", cur_test, what, exp, act);
            fail_now();
        end
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic disp_req_t make_req(input alu_op_e op,
                                           input logic [PREG_W-1:0] prs1,
                                           input logic [PREG_W-1:0] prs2,
                                           input logic [PREG_W-1:0] prd,
                                           input logic is_imm,
                                           input logic [XLEN-1:0] imm);
        disp_req_t r;
        r.pc     = rand32();
        r.op     = op;
        r.prs1   = prs1;
        r.prs2   = prs2;
        r.prd    = prd;
        r.imm    = imm;
        r.is_imm = is_imm;
        return r;
    endfunction

    // Packet from the FU against the model
    task automatic check_pkt(input issue_pkt_t pkt);
        disp_req_t       r;
        logic [XLEN-1:0] exp_src2;
        assert (pend_v[pkt.id]) else begin
            $display("Packet with ID %0d has no pending dispatch in %s", pkt.id, cur_test);
            fail_now();
        end
        r = pend_req[pkt.id];
        assert (!busy_m[r.prs1] && (r.is_imm || !busy_m[r.prs2])) else begin
            $display("Packet with ID %0d issued before its sources were written", pkt.id);
            fail_now();
        end
        exp_src2 = r.is_imm ? r.imm : regs_m[r.prs2];
        check_val("pc", XLEN'(r.pc), XLEN'(pkt.pc));
        check_val("op", XLEN'(r.op), XLEN'(pkt.op));
        check_val("prd", XLEN'(r.prd), XLEN'(pkt.prd));
        check_val("src1", regs_m[r.prs1], pkt.src1);
        check_val("src2", exp_src2, pkt.src2);
        pend_v[pkt.id] = 1'b0;
        n_pend--;
        got_ids.push_back(pkt.id);
        last_pkt = pkt;
    endtask

    // Sample before the edge and update the model after it
    task automatic tick();
        logic      took;
        wb_t       w;
        disp_req_t r;
        @(negedge clk);
        acc_seen = in_valid && in_ready;
        took     = out_valid && out_ready;
        ov_seen  = out_valid;
        pkt_seen = out_pkt;
        w        = wb;
        r        = in_req;
        @(posedge clk);
        #1;
        if (took) check_pkt(pkt_seen);
        if (w.valid) begin
            busy_m[w.prd] = 1'b0;
            if (w.prd != '0) regs_m[w.prd] = w.data;
        end
        if (acc_seen) begin
            pend_req[next_id] = r;
            pend_v[next_id]   = 1'b1;
            n_pend++;
            if (r.prd != '0) busy_m[r.prd] = 1'b1;  // Allocate after free
            next_id++;
        end
        wb.valid = 1'b0;   // Single-cycle strobe
        assert (isu_top_i.isu_checker_i.fail_cnt == 0) else begin
            $display("A protocol assertion on the DUT ports fired during %s", cur_test);
            fail_now();
        end
    endtask

    task automatic send(input disp_req_t r);
        in_valid = 1'b1;
        in_req   = r;
        tick();
        while (!acc_seen) tick();
        in_valid = 1'b0;
    endtask

    task automatic write_back(input logic [PREG_W-1:0] prd, input logic [XLEN-1:0] data);
        wb.valid = 1'b1;
        wb.prd   = prd;
        wb.data  = data;
    endtask

    function automatic logic src_in_use(input logic [PREG_W-1:0] p);
        for (int i = 0; i < NUM_IDS; i++) begin
            if (pend_v[i] && ((pend_req[i].prs1 == p) ||
                              (!pend_req[i].is_imm && (pend_req[i].prs2 == p)))) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Free destination that no waiting instruction still reads
    function automatic logic [PREG_W-1:0] pick_free(input disp_req_t r);
        logic [PREG_W-1:0] p;
        p = PREG_W'(rand32() % 32'd64);
        for (int i = 0; i < NUM_PREGS; i++) begin
            if ((p != '0) && !busy_m[p] && (p != r.prs1) && (p != r.prs2) && !src_in_use(p)) begin
                return p;
            end
            p = p + 1'b1;
        end
        return '0;
    endfunction

    function automatic logic [PREG_W-1:0] pick_busy();
        logic [PREG_W-1:0] p;
        p = PREG_W'(rand32() % 32'd64);
        for (int i = 0; i < NUM_PREGS; i++) begin
            if (busy_m[p]) return p;
            p = p + 1'b1;
        end
        return '0;
    endfunction

    //----------------------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------------------
    task automatic reset_state();
        cur_test = "reset_state";
        @(negedge clk);
        check_val("in_ready", 64'd1, XLEN'(in_ready));
        check_val("out_valid", 64'd0, XLEN'(out_valid));
        @(posedge clk);
        #1;
    endtask

    task automatic ready_issue();
        int edges;
        cur_test  = "ready_issue";
        out_ready = 1'b1;
        got_ids.delete();
        for (int k = 0; k < 4; k++) begin
            // First one reads p0 and the others untouched registers
            send(make_req(alu_op_e'(4'(k + 1)), PREG_W'(k == 0 ? 0 : 10 + k), 6'd0,
                          PREG_W'(20 + k), 1'b1, {rand32(), rand32()}));
            edges = 1;
            tick();
            while (!ov_seen) begin
                edges++;
                tick();
            end
            check_val("latency", 64'd2, XLEN'(edges));
            check_val("packets", XLEN'(k + 1), XLEN'(got_ids.size()));
            check_val("id", XLEN'(k), XLEN'(got_ids[k]));
        end
    endtask

    task automatic wakeup();
        logic [XLEN-1:0] data;
        cur_test  = "wakeup";
        out_ready = 1'b1;
        send(make_req(ALU_ADD, 6'd0, 6'd0, 6'd30, 1'b1, 64'h30));
        send(make_req(ALU_SUB, 6'd30, 6'd0, 6'd31, 1'b0, 64'h0));
        repeat (6) tick();
        check_val("pending before wb", 64'd1, XLEN'(n_pend));
        write_back(6'd30, 64'h1111_2222_3333_4444);
        repeat (7) tick();
        check_val("pending after wb", 64'd0, XLEN'(n_pend));
        check_val("woken src1", 64'h1111_2222_3333_4444, last_pkt.src1);

        // Writeback on the dispatch edge is seen through forwarding
        send(make_req(ALU_AND, 6'd0, 6'd0, 6'd32, 1'b1, 64'h32));
        while (n_pend > 0) tick();
        data     = {rand32(), rand32()};
        in_valid = 1'b1;
        in_req   = make_req(ALU_XOR, 6'd32, 6'd0, 6'd33, 1'b0, 64'h0);
        write_back(6'd32, data);
        tick();
        in_valid = 1'b0;
        check_val("accepted", 64'd1, XLEN'(acc_seen));
        repeat (6) tick();
        check_val("pending after forward", 64'd0, XLEN'(n_pend));
        check_val("forwarded src1", data, last_pkt.src1);
    endtask

    task automatic ooo_select();
        logic [ID_W-1:0] old_id;
        logic [ID_W-1:0] young_id;
        cur_test  = "ooo_select";
        out_ready = 1'b1;
        send(make_req(ALU_OR, 6'd0, 6'd0, 6'd40, 1'b1, 64'h40));
        while (n_pend > 0) tick();
        got_ids.delete();
        old_id = next_id;
        send(make_req(ALU_SLT, 6'd40, 6'd0, 6'd41, 1'b0, 64'h0));
        young_id = next_id;
        send(make_req(ALU_SLTU, 6'd0, 6'd0, 6'd42, 1'b1, 64'h42));
        repeat (6) tick();
        check_val("issued before wakeup", 64'd1, XLEN'(got_ids.size()));
        check_val("first id", XLEN'(young_id), XLEN'(got_ids[0]));
        write_back(6'd40, 64'h0bad_cafe_1234_5678);
        repeat (7) tick();
        check_val("pending after wakeup", 64'd0, XLEN'(n_pend));
        check_val("second id", XLEN'(old_id), XLEN'(got_ids[1]));
    endtask

    task automatic backpressure();
        logic [ID_W-1:0] exp_id;
        cur_test  = "backpressure";
        out_ready = 1'b0;
        got_ids.delete();
        exp_id = next_id;
        // Output register plus eight queued entries
        for (int k = 0; k < ISQ_DEPTH + 1; k++) begin
            send(make_req(ALU_SRA, 6'd0, 6'd0, 6'd0, 1'b1, XLEN'(k)));
        end
        in_valid = 1'b1;
        in_req   = make_req(ALU_ADD, 6'd0, 6'd0, 6'd0, 1'b1, 64'hffff);
        for (int k = 0; k < 5; k++) begin
            tick();
            check_val("accept while full", 64'd0, XLEN'(acc_seen));
            check_val("valid under stall", 64'd1, XLEN'(ov_seen));
            check_val("held id", XLEN'(exp_id), XLEN'(pkt_seen.id));
            check_val("held src2", 64'd0, pkt_seen.src2);
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while (n_pend > 0) tick();
        for (int k = 0; k < ISQ_DEPTH + 1; k++) begin
            check_val("drain order", XLEN'(exp_id), XLEN'(got_ids[k]));
            exp_id++;
        end
    endtask

    task automatic random_mix();
        disp_req_t         r;
        logic [PREG_W-1:0] p;
        int                sent;
        cur_test = "random_mix";
        got_ids.delete();
        sent = 0;
        while (sent < NUM_RANDOM) begin
            if (!in_valid && ((rand32() % 32'd100) < 32'd70)) begin
                r.pc     = rand32();
                r.op     = alu_op_e'(4'(rand32() % 32'd10));
                r.prs1   = PREG_W'(rand32() % 32'd64);
                r.prs2   = PREG_W'(rand32() % 32'd64);
                r.imm    = {rand32(), rand32()};
                r.is_imm = (rand32() % 32'd2) == 32'd1;
                r.prd    = pick_free(r);
                in_valid = 1'b1;
                in_req   = r;
            end
            p = pick_busy();
            if ((p != '0) && ((rand32() % 32'd100) < 32'd30)) write_back(p, {rand32(), rand32()});
            out_ready = (rand32() % 32'd100) < 32'd70;
            tick();
            if (acc_seen) begin
                in_valid = 1'b0;
                sent++;
            end
        end
        // Wake whatever still sleeps and drain
        out_ready = 1'b1;
        while (n_pend > 0) begin
            p = pick_busy();
            if (p != '0) write_back(p, {rand32(), rand32()});
            tick();
        end
        check_val("packets", XLEN'(NUM_RANDOM), XLEN'(got_ids.size()));
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        wb        = '0;
        out_ready = 1'b0;
        cycles    = 0;
        busy_m    = '0;
        pend_v    = '0;
        n_pend    = 0;
        next_id   = '0;
        for (int i = 0; i < NUM_PREGS; i++) begin
            regs_m[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        reset_state();
        ready_issue();
        wakeup();
        ooo_select();
        backpressure();
        random_mix();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: rtl/busy_table.sv
`timescale 1ns/1ns

module busy_table
    import isu_cfg_pkg::*, isu_types_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    // Source lookup from dispatch
    input  logic [PREG_W-1:0] rd_prs1,
    input  logic [PREG_W-1:0] rd_prs2,
    output logic              rs1_busy,
    output logic              rs2_busy,

    // Destination allocate
    input  logic              alloc_en,
    input  logic [PREG_W-1:0] alloc_prd,

    // Free on writeback
    input  wb_t               wb
);

    logic [NUM_PREGS-1:0] busy_q;

    // Busy unless p0 or freed by this cycle's writeback
    function automatic logic lookup(input logic [NUM_PREGS-1:0] vec,
                                    input logic [PREG_W-1:0]    idx,
                                    input wb_t                  w);
        logic freed;
        freed  = w.valid && (w.prd == idx);
        lookup = vec[idx] && (idx != '0) && !freed;
    endfunction

    assign rs1_busy = lookup(busy_q, rd_prs1, wb);
    assign rs2_busy = lookup(busy_q, rd_prs2, wb);

    //----------------------------------------------------------------------
    // Busy vector update
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else begin
            if (wb.valid) begin
                busy_q[wb.prd] <= 1'b0;
            end
            // Later assignment, so allocate beats a free of the same preg
            if (alloc_en) begin
                busy_q[alloc_prd] <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/dispatch.sv
`timescale 1ns/1ns

module dispatch
    import isu_cfg_pkg::*, isu_types_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    // Rename handshake
    input  logic              in_valid,
    output logic              in_ready,
    input  disp_req_t         in_req,

    // Busy table lookup
    output logic [PREG_W-1:0] rd_prs1,
    output logic [PREG_W-1:0] rd_prs2,
    input  logic              rs1_busy,
    input  logic              rs2_busy,

    // Busy table allocate
    output logic              alloc_en,
    output logic [PREG_W-1:0] alloc_prd,

    // Issue queue write
    input  logic              isq_full,
    output logic              isq_wr_en,
    output isq_entry_t        isq_entry
);

    logic            fire;
    logic [ID_W-1:0] id_q;

    assign in_ready = !isq_full;
    assign fire     = in_valid && in_ready;

    assign rd_prs1  = in_req.prs1;
    assign rd_prs2  = in_req.prs2;

    // p0 is a constant zero, nothing to track
    assign alloc_en  = fire && (in_req.prd != '0);
    assign alloc_prd = in_req.prd;

    //----------------------------------------------------------------------
    // Queue entry
    //----------------------------------------------------------------------
    assign isq_wr_en           = fire;
    assign isq_entry.req       = in_req;
    assign isq_entry.id        = id_q;
    assign isq_entry.rs1_sleep = rs1_busy;
    assign isq_entry.rs2_sleep = rs2_busy && !in_req.is_imm;  // imm needs no preg

    // Sequential ID, wraps at 2**ID_W
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_q <= '0;
        end else if (fire) begin
            id_q <= id_q + 1'b1;
        end
    end

endmodule

// File: rtl/issue_queue.sv
`timescale 1ns/1ns

module issue_queue
    import isu_cfg_pkg::*, isu_types_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    // From dispatch
    input  logic              wr_en,
    input  isq_entry_t        wr_entry,
    output logic              full,

    // Wakeup
    input  wb_t               wb,

    // Register file read
    output logic [PREG_W-1:0] rd_idx1,
    output logic [PREG_W-1:0] rd_idx2,
    input  logic [XLEN-1:0]   rd_data1,
    input  logic [XLEN-1:0]   rd_data2,

    // To FU
    output logic              out_valid,
    input  logic              out_ready,
    output issue_pkt_t        out_pkt
);

    isq_entry_t           ent_q [ISQ_DEPTH];
    isq_entry_t           ent_d [ISQ_DEPTH];
    logic [ISQ_CNT_W-1:0] cnt_q;
    logic [ISQ_CNT_W-1:0] cnt_pop;     // Count after this cycle's pop
    logic [ISQ_CNT_W-1:0] cnt_d;

    logic [ISQ_DEPTH-1:0] ready;
    logic [ISQ_IDX_W-1:0] sel_idx;
    logic                 out_free;
    logic                 pop;
    isq_entry_t           sel_ent;

    issue_pkt_t           pkt_d;
    issue_pkt_t           pkt_q;
    logic                 vld_q;

    //----------------------------------------------------------------------
    // Select the oldest entry with both sources awake
    //----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < ISQ_DEPTH; i++) begin
            ready[i] = (i < cnt_q) && !ent_q[i].rs1_sleep && !ent_q[i].rs2_sleep;
        end
    end

    always_comb begin
        sel_idx = '0;
        // Walk downward so the lowest index wins
        for (int i = ISQ_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel_idx = ISQ_IDX_W'(i);
            end
        end
    end

    assign out_free = !vld_q || out_ready;
    assign pop      = (|ready) && out_free;
    assign sel_ent  = ent_q[sel_idx];

    assign cnt_pop  = cnt_q - ISQ_CNT_W'(pop);
    assign full     = (cnt_pop == ISQ_CNT_W'(ISQ_DEPTH));

    // Operand read for the selected entry
    assign rd_idx1  = sel_ent.req.prs1;
    assign rd_idx2  = sel_ent.req.prs2;

    always_comb begin
        pkt_d.id   = sel_ent.id;
        pkt_d.pc   = sel_ent.req.pc;
        pkt_d.op   = sel_ent.req.op;
        pkt_d.prd  = sel_ent.req.prd;
        pkt_d.src1 = rd_data1;
        pkt_d.src2 = sel_ent.req.is_imm ? sel_ent.req.imm : rd_data2;
    end

    //----------------------------------------------------------------------
    // Next queue contents: wakeup, collapse, then append
    //----------------------------------------------------------------------
    always_comb begin
        ent_d = ent_q;

        if (wb.valid) begin
            for (int i = 0; i < ISQ_DEPTH; i++) begin
                if (ent_d[i].req.prs1 == wb.prd) ent_d[i].rs1_sleep = 1'b0;
                if (ent_d[i].req.prs2 == wb.prd) ent_d[i].rs2_sleep = 1'b0;
            end
        end

        if (pop) begin
            for (int i = 0; i < ISQ_DEPTH - 1; i++) begin
                if (i >= sel_idx) begin
                    ent_d[i] = ent_d[i + 1];  // Shift down over the popped slot
                end
            end
        end

        // New entry lands at the first free slot after the collapse
        for (int i = 0; i < ISQ_DEPTH; i++) begin
            if (wr_en && (i == cnt_pop)) begin
                ent_d[i] = wr_entry;
            end
        end

        cnt_d = cnt_pop + ISQ_CNT_W'(wr_en);
    end

    //----------------------------------------------------------------------
    // State
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
            vld_q <= 1'b0;
        end else begin
            cnt_q <= cnt_d;
            if (out_free) begin
                vld_q <= pop;
            end
        end
    end

    always_ff @(posedge clk) begin
        ent_q <= ent_d;
        if (pop) begin
            pkt_q <= pkt_d;   // Held while the FU stalls
        end
    end

    assign out_valid = vld_q;
    assign out_pkt   = pkt_q;

endmodule

// File: rtl/isu_cfg_pkg.sv
package isu_cfg_pkg;

    //----------------------------------------------------------------------
    // Datapath widths
    //----------------------------------------------------------------------
    localparam int XLEN      = 64;   // Operand and immediate width
    localparam int PC_W      = 32;

    //----------------------------------------------------------------------
    // Physical register space
    //----------------------------------------------------------------------
    localparam int PREG_W    = 6;
    localparam int NUM_PREGS = 64;   // 2**PREG_W

    // Instruction ID wraps at 2**ID_W
    localparam int ID_W      = 7;

    //----------------------------------------------------------------------
    // Issue queue sizing
    //----------------------------------------------------------------------
    localparam int ISQ_DEPTH = 8;
    localparam int ISQ_CNT_W = 4;    // Counts 0..ISQ_DEPTH
    localparam int ISQ_IDX_W = 3;    // Entry index

endpackage

// File: rtl/isu_top.sv
`timescale 1ns/1ns

module isu_top
    import isu_cfg_pkg::*, isu_types_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    // Rename side
    input  logic       in_valid,
    output logic       in_ready,
    input  disp_req_t  in_req,

    // Writeback strobe
    input  wb_t        wb,

    // FU side
    output logic       out_valid,
    input  logic       out_ready,
    output issue_pkt_t out_pkt
);

    // Dispatch <-> busy table
    logic [PREG_W-1:0] bt_rd_prs1;
    logic [PREG_W-1:0] bt_rd_prs2;
    logic              bt_rs1_busy;
    logic              bt_rs2_busy;
    logic              bt_alloc_en;
    logic [PREG_W-1:0] bt_alloc_prd;

    // Dispatch -> issue queue
    logic              isq_full;
    logic              isq_wr_en;
    isq_entry_t        isq_entry;

    // Issue queue <-> register file
    logic [PREG_W-1:0] prf_rd_idx1;
    logic [PREG_W-1:0] prf_rd_idx2;
    logic [XLEN-1:0]   prf_rd_data1;
    logic [XLEN-1:0]   prf_rd_data2;

    //----------------------------------------------------------------------
    // Dispatch
    //----------------------------------------------------------------------
    dispatch dispatch_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .rd_prs1   (bt_rd_prs1),
        .rd_prs2   (bt_rd_prs2),
        .rs1_busy  (bt_rs1_busy),
        .rs2_busy  (bt_rs2_busy),
        .alloc_en  (bt_alloc_en),
        .alloc_prd (bt_alloc_prd),
        .isq_full  (isq_full),
        .isq_wr_en (isq_wr_en),
        .isq_entry (isq_entry)
    );

    //----------------------------------------------------------------------
    // Busy table and register file, both written by wb
    //----------------------------------------------------------------------
    busy_table busy_table_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_prs1   (bt_rd_prs1),
        .rd_prs2   (bt_rd_prs2),
        .rs1_busy  (bt_rs1_busy),
        .rs2_busy  (bt_rs2_busy),
        .alloc_en  (bt_alloc_en),
        .alloc_prd (bt_alloc_prd),
        .wb        (wb)
    );

    preg_file preg_file_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_idx1  (prf_rd_idx1),
        .rd_idx2  (prf_rd_idx2),
        .rd_data1 (prf_rd_data1),
        .rd_data2 (prf_rd_data2),
        .wb       (wb)
    );

    //----------------------------------------------------------------------
    // Issue queue
    //----------------------------------------------------------------------
    issue_queue issue_queue_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (isq_wr_en),
        .wr_entry  (isq_entry),
        .full      (isq_full),
        .wb        (wb),            // Wakeup
        .rd_idx1   (prf_rd_idx1),
        .rd_idx2   (prf_rd_idx2),
        .rd_data1  (prf_rd_data1),
        .rd_data2  (prf_rd_data2),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pkt   (out_pkt)
    );

endmodule

// File: rtl/isu_types_pkg.sv
package isu_types_pkg;

    import isu_cfg_pkg::*;

    // Decoded ALU operation
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    //----------------------------------------------------------------------
    // Rename to dispatch
    //----------------------------------------------------------------------
    typedef struct packed {
        logic [PC_W-1:0]   pc;
        alu_op_e           op;
        logic [PREG_W-1:0] prs1;
        logic [PREG_W-1:0] prs2;
        logic [PREG_W-1:0] prd;
        logic [XLEN-1:0]   imm;
        logic              is_imm;    // src2 comes from imm
    } disp_req_t;

    // Issue queue slot
    typedef struct packed {
        disp_req_t       req;
        logic [ID_W-1:0] id;
        logic            rs1_sleep;
        logic            rs2_sleep;
    } isq_entry_t;

    // Single writeback port
    typedef struct packed {
        logic              valid;
        logic [PREG_W-1:0] prd;
        logic [XLEN-1:0]   data;
    } wb_t;

    //----------------------------------------------------------------------
    // Issue queue to FU
    //----------------------------------------------------------------------
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [PC_W-1:0]   pc;
        alu_op_e           op;
        logic [PREG_W-1:0] prd;
        logic [XLEN-1:0]   src1;
        logic [XLEN-1:0]   src2;
    } issue_pkt_t;

endpackage

// File: rtl/preg_file.sv
`timescale 1ns/1ns

module preg_file
    import isu_cfg_pkg::*, isu_types_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    // Operand reads for the selected entry
    input  logic [PREG_W-1:0] rd_idx1,
    input  logic [PREG_W-1:0] rd_idx2,
    output logic [XLEN-1:0]   rd_data1,
    output logic [XLEN-1:0]   rd_data2,

    // Writeback port
    input  wb_t               wb
);

    logic [XLEN-1:0] regs_q [NUM_PREGS];

    // p0 is never written, so it always reads zero
    assign rd_data1 = regs_q[rd_idx1];
    assign rd_data2 = regs_q[rd_idx2];

    //----------------------------------------------------------------------
    // Write port
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb.valid && (wb.prd != '0)) begin
            regs_q[wb.prd] <= wb.data;
        end
    end

endmodule

// File: sim.f
rtl/isu_cfg_pkg.sv
rtl/isu_types_pkg.sv
rtl/busy_table.sv
rtl/preg_file.sv
rtl/dispatch.sv
rtl/issue_queue.sv
rtl/isu_top.sv
dv/isu_checker.sv
dv/isu_tb.sv
